// File: filelist.f
src/mips_pkg.sv
src/alu.sv
src/register_file.sv
src/control_unit.sv
src/mips.sv
src/unified_memory.sv
src/mips_system.sv
sim/tb_clock.sv
sim/mips_properties.sv
sim/tb_mips_system.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mips_system -f filelist.f -o sim_mips

./obj_dir/sim_mips > sim.log 2>&1 || true
cat sim.log

if grep -qx "Result: PASSED" sim.log; then
	exit 0
else
	exit 1
fi

// File: sim/mips_properties.sv
`timescale 1ns/1ps

module mips_properties (
	input logic            clk,
	input logic            rstb,
	input mips_pkg::ctrl_t ctrl,
	input logic            done,
	input logic [31:0]     pc
);

	// store strobe and register write are separate states
	a_no_wr_overlap: assert property (@(posedge clk) disable iff (!rstb)
		!(ctrl.mem_write && ctrl.reg_write))
		else $error("store and register write high together");

	// ir_write is raised only in the fetch state
	a_done_then_fetch: assert property (@(posedge clk) disable iff (!rstb)
		done |=> ctrl.ir_write)
		else $error("instr_done not followed by fetch");

	a_reset_state: assert property (@(posedge clk)
		$rose(rstb) |-> (pc == 32'd0) && !ctrl.mem_write)
		else $error("pc or store strobe wrong after reset");

endmodule

// control word from the FSM, done and pc from the top level ports
bind mips_system mips_properties u_props (
	.clk  (clk),
	.rstb (rstb),
	.ctrl (ctrl),
	.done (instr_done),
	.pc   (pc)
);

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	localparam real half_period = 4.0;  // 8 ns period

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

endmodule

// File: sim/tb_mips_system.sv
`timescale 1ns/1ps

module tb_mips_system;

	localparam int prog_len   = 200;
	localparam int timeout    = 5000;
	localparam int park_count = 8;  // extra retirements of the self jump

	logic        clk, rstb, load_ena;
	logic [9:0]  load_addr;
	logic [31:0] load_data, pc, mem_addr, mem_wr_data;
	logic        instr_done, mem_wr_ena;

	int          seed;
	int          errors, checks, stores_seen;
	logic [31:0] prog [prog_len];
	logic [31:0] m_mem [1024];    // model memory, also the boot image
	logic [31:0] m_reg [32];
	logic [31:0] exp_pc [$];      // pc after each instruction
	int          exp_lat [$];     // cycles per instruction
	logic [31:0] st_addr [$], st_data [$];
	logic [5:0]  r_fns [10] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
	                           6'h2a, 6'h2b, 6'h00, 6'h02};
	logic [5:0]  i_ops [6]  = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

	tb_clock u_clk (.clk(clk));

	mips_system i_dut (
		.clk (clk), .rstb (rstb), .load_ena (load_ena), .load_addr (load_addr),
		.load_data (load_data), .pc (pc), .instr_done (instr_done),
		.mem_wr_ena (mem_wr_ena), .mem_addr (mem_addr), .mem_wr_data (mem_wr_data)
	);

	function automatic int rand_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// r2 holds the data base, never a destination
	function automatic logic [4:0] pick_dst();
		logic [4:0] r;
		r = 5'd2;
		while (r == 5'd2)
			r = 5'(1 + rand_below(15));
		return r;
	endfunction

	function automatic logic [31:0] enc_i(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
	                                      logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] enc_r(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
	                                      logic [4:0] sh, logic [5:0] fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	task automatic gen_program();
		int i, sel, off, guard;
		logic [4:0] rs, rt;
		guard = 0;
		prog[0] = enc_i(6'h09, 5'd0, 5'd2, 16'h0800);  // r2 = 2048
		i = 1;
		while (i < 195) begin
			sel = rand_below(10);
			rs  = 5'(1 + rand_below(15));
			rt  = 5'(1 + rand_below(15));
			off = rand_below(16) * 4;  // aligned data offset
			if (guard > 0)
				guard--;
			if (sel <= 3) begin
				prog[i] = enc_r(rs, rt, pick_dst(), 5'(rand_below(32)), r_fns[rand_below(10)]);
				i++;
			end else if (sel <= 5) begin
				prog[i] = enc_i(i_ops[rand_below(6)], rs, pick_dst(), 16'($random(seed)));
				i++;
			end else if (sel == 6) begin
				prog[i] = enc_i(6'h2b, 5'd2, rt, 16'(off));
				i++;
			end else if (sel == 7) begin
				prog[i] = enc_i(6'h23, 5'd2, pick_dst(), 16'(off));
				i++;
			end else if (sel == 8) begin
				if (rand_below(2) == 1)
					rt = rs;  // equal operands half the time
				sel = rand_below(4);  // forward word offset
				prog[i] = enc_i(rand_below(2) ? 6'h05 : 6'h04, rs, rt, 16'(sel));
				guard = (sel + 1 > guard) ? sel + 1 : guard;  // no jal block in the skip
				i++;
			end else if (guard == 0) begin
				// jal over one word, store link, bump it, return past the block
				prog[i]   = {6'h03, 26'(i + 2)};
				prog[i+1] = enc_i(6'h09, 5'd1, 5'd1, 16'd1);
				prog[i+2] = enc_i(6'h2b, 5'd2, 5'd31, 16'(off));
				prog[i+3] = enc_i(6'h09, 5'd31, 5'd31, 16'd16);
				prog[i+4] = enc_r(5'd31, 5'd0, 5'd0, 5'd0, 6'h08);
				i += 5;
			end else begin
				sel = rand_below(3);
				prog[i] = {6'h02, 26'(i + 1 + sel)};
				guard = (sel + 1 > guard) ? sel + 1 : guard;
				i++;
			end
		end
		for (; i < prog_len - 1; i++)
			prog[i] = 32'h0;  // sll r0 nop
		prog[prog_len-1] = {6'h02, 26'(prog_len - 1)};  // self jump
	endtask

	function automatic logic [31:0] r_alu(logic [5:0] fn, logic [31:0] a, logic [31:0] b,
	                                      logic [4:0] sh);
		case (fn)
			6'h21: return a + b;
			6'h23: return a - b;
			6'h24: return a & b;
			6'h25: return a | b;
			6'h26: return a ^ b;
			6'h27: return ~(a | b);
			6'h2a: return {31'b0, $signed(a) < $signed(b)};
			6'h2b: return {31'b0, a < b};
			6'h00: return b << sh;
			default: return b >> sh;  // srl
		endcase
	endfunction

	task automatic write_reg(logic [4:0] r, logic [31:0] v);
		if (r != 5'd0)
			m_reg[r] = v;
	endtask

	task automatic run_model();
		logic [31:0] cur, ins, nxt, rs_v, rt_v, sext, zext, addr;
		int lat;
		cur = 32'd0;
		for (int step = 0; step < timeout; step++) begin
			ins  = m_mem[cur[11:2]];
			rs_v = m_reg[ins[25:21]];
			rt_v = m_reg[ins[20:16]];
			sext = {{16{ins[15]}}, ins[15:0]};
			zext = {16'b0, ins[15:0]};
			nxt  = cur + 32'd4;
			lat  = 4;
			case (ins[31:26])
				6'h00: begin
					if (ins[5:0] == 6'h08) begin
						nxt = rs_v;  // jr
						lat = 3;
					end else
						write_reg(ins[15:11], r_alu(ins[5:0], rs_v, rt_v, ins[10:6]));
				end
				6'h02, 6'h03: begin
					if (ins[31:26] == 6'h03)
						write_reg(5'd31, cur + 32'd4);
					nxt = {nxt[31:28], ins[25:0], 2'b00};
					lat = 3;
				end
				6'h04, 6'h05: begin
					lat = 3;
					if ((rs_v == rt_v) == (ins[31:26] == 6'h04))
						nxt = cur + 32'd4 + (sext << 2);
				end
				6'h09: write_reg(ins[20:16], rs_v + sext);
				6'h0a: write_reg(ins[20:16], {31'b0, $signed(rs_v) < $signed(sext)});
				6'h0c: write_reg(ins[20:16], rs_v & zext);
				6'h0d: write_reg(ins[20:16], rs_v | zext);
				6'h0e: write_reg(ins[20:16], rs_v ^ zext);
				6'h0f: write_reg(ins[20:16], {ins[15:0], 16'b0});
				6'h23: begin
					addr = rs_v + sext;
					write_reg(ins[20:16], m_mem[addr[11:2]]);
					lat = 5;
				end
				6'h2b: begin
					addr = rs_v + sext;
					m_mem[addr[11:2]] = rt_v;
					st_addr.push_back(addr);
					st_data.push_back(rt_v);
				end
				default: ;
			endcase
			exp_pc.push_back(nxt);
			exp_lat.push_back(lat);
			if (nxt == cur)
				break;  // self jump reached
			cur = nxt;
		end
	endtask

	// every store checked against the model queue
	always @(negedge clk) begin
		if (rstb && mem_wr_ena) begin
			checks++;
			assert (stores_seen < st_addr.size()) else begin
				errors++;
				$display("unexpected extra store at time %0t", $time);
			end
			if (stores_seen < st_addr.size()) begin
				assert (mem_addr == st_addr[stores_seen] && mem_wr_data == st_data[stores_seen])
				else begin
					errors++;
					$display("MISMATCH t=%0t store %0d addr %h data %h, expected %h %h", $time,
					         stores_seen, mem_addr, mem_wr_data, st_addr[stores_seen],
					         st_data[stores_seen]);
				end
			end
			stores_seen++;
		end
	end

	initial begin
		int cnt, want_lat;
		logic [31:0] final_pc, want_pc;
		rstb = 1'b0;
		load_ena = 1'b0;
		load_addr = '0;
		load_data = '0;
		errors = 0;
		checks = 0;
		stores_seen = 0;
		seed = 32'hddef_d668;
		gen_program();
		for (int k = 0; k < 1024; k++)  // program, then address-hashed fill
			m_mem[k] = (k < prog_len) ? prog[k] : (32'(k) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
		for (int r = 0; r < 32; r++)
			m_reg[r] = 32'd0;
		for (int k = 0; k < 1024; k++) begin
			@(posedge clk);
			load_ena  <= 1'b1;
			load_addr <= 10'(k);
			load_data <= m_mem[k];
		end
		@(posedge clk);
		load_ena <= 1'b0;
		run_model();  // after the image is sent, model now mutates its copy
		repeat (3) @(posedge clk);
		rstb <= 1'b1;
		cnt = 0;
		final_pc = exp_pc[$];
		for (int n = 0; n < exp_pc.size() + park_count; n++) begin
			// past the model trace the self jump retires again in place
			if (n < exp_pc.size()) begin
				want_pc  = exp_pc[n];
				want_lat = exp_lat[n];
			end else begin
				want_pc  = final_pc;
				want_lat = exp_lat[$];
			end
			do begin
				@(negedge clk);
				cnt++;
			end while (!instr_done && cnt < timeout);
			if (!instr_done) begin
				errors++;
				$display("timeout at %0t waiting for instr_done of instruction %0d", $time, n);
				break;
			end
			checks++;
			assert (cnt == want_lat) else begin
				errors++;
				$display("MISMATCH t=%0t instr %0d took %0d cycles, expected %0d", $time, n,
				         cnt, want_lat);
			end
			@(negedge clk);  // pc valid the cycle after the pulse
			cnt = 1;
			checks++;
			assert (pc == want_pc) else begin
				errors++;
				$display("MISMATCH t=%0t instr %0d pc %h, expected %h", $time, n, pc, want_pc);
			end
		end
		checks++;
		assert (stores_seen == st_addr.size()) else begin
			errors++;
			$display("MISMATCH t=%0t store count %0d, expected %0d", $time, stores_seen,
			         st_addr.size());
		end
		$display("errors: %0d checks: %0d", errors, checks);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: src/alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [mips_pkg::word_w-1:0] a,
	input  logic [mips_pkg::word_w-1:0] b,
	input  mips_pkg::alu_op_e           op,
	output logic [mips_pkg::word_w-1:0] result,
	output logic                        zero
);

	localparam int w = mips_pkg::word_w;

	logic [4:0] shamt;
	logic       lt_s, lt_u;

	assign shamt = a[4:0];  // shifts take the amount from a
	assign lt_s  = $signed(a) < $signed(b);
	assign lt_u  = a < b;

	always_comb begin
		case (op)
			mips_pkg::alu_add:  result = a + b;
			mips_pkg::alu_sub:  result = a - b;
			mips_pkg::alu_and:  result = a & b;
			mips_pkg::alu_or:   result = a | b;
			mips_pkg::alu_xor:  result = a ^ b;
			mips_pkg::alu_nor:  result = ~(a | b);
			mips_pkg::alu_slt:  result = {{(w-1){1'b0}}, lt_s};
			mips_pkg::alu_sltu: result = {{(w-1){1'b0}}, lt_u};
			mips_pkg::alu_sll:  result = b << shamt;
			mips_pkg::alu_srl:  result = b >> shamt;  // logical, zero fill
			mips_pkg::alu_lui:  result = {b[15:0], 16'b0};
			default:            result = '0;
		endcase
	end

	assign zero = (result == '0);  // branch compare

endmodule

// File: src/control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  logic            clk,
	input  logic            rstb,
	input  logic [31:0]     instr,
	output mips_pkg::ctrl_t ctrl,
	output logic            instr_done
);

	mips_pkg::ctrl_state_e state, next_state;
	mips_pkg::opcode_e     opcode;
	mips_pkg::funct_e      funct;
	logic                  is_shift;

	assign opcode   = mips_pkg::opcode_e'(instr[31:26]);
	assign funct    = mips_pkg::funct_e'(instr[5:0]);
	assign is_shift = (funct == mips_pkg::fn_sll) || (funct == mips_pkg::fn_srl);

	always_ff @(posedge clk) begin
		if (!rstb)
			state <= mips_pkg::st_fetch;
		else
			state <= next_state;
	end

	always_comb begin
		ctrl       = '0;  // all strobes low, selects at code 0
		instr_done = 1'b0;
		next_state = mips_pkg::st_fetch;
		case (state)
			mips_pkg::st_fetch: begin
				// ir <= mem[pc], pc <= pc + 4
				ctrl.ir_write  = 1'b1;
				ctrl.pc_write  = 1'b1;
				ctrl.alu_src_a = mips_pkg::src_a_pc;
				ctrl.alu_src_b = mips_pkg::src_b_four;
				ctrl.alu_op    = mips_pkg::alu_add;
				ctrl.pc_src    = mips_pkg::pc_alu_result;
				next_state     = mips_pkg::st_decode;
			end
			mips_pkg::st_decode: begin
				// branch target precomputed into alu_out
				ctrl.alu_src_a = mips_pkg::src_a_pc;
				ctrl.alu_src_b = mips_pkg::src_b_ext_sl2;
				ctrl.alu_op    = mips_pkg::alu_add;
				case (opcode)
					mips_pkg::op_rtype: begin
						case (funct)
							mips_pkg::fn_jr: next_state = mips_pkg::st_jump;
							mips_pkg::fn_sll, mips_pkg::fn_srl, mips_pkg::fn_addu,
							mips_pkg::fn_subu, mips_pkg::fn_and, mips_pkg::fn_or,
							mips_pkg::fn_xor, mips_pkg::fn_nor, mips_pkg::fn_slt,
							mips_pkg::fn_sltu: next_state = mips_pkg::st_exec_r;
							default: instr_done = 1'b1;  // unknown funct, no-op
						endcase
					end
					mips_pkg::op_j, mips_pkg::op_jal: next_state = mips_pkg::st_jump;
					mips_pkg::op_beq, mips_pkg::op_bne: next_state = mips_pkg::st_branch;
					mips_pkg::op_lw, mips_pkg::op_sw: next_state = mips_pkg::st_mem_addr;
					mips_pkg::op_addiu, mips_pkg::op_slti, mips_pkg::op_sltiu,
					mips_pkg::op_andi, mips_pkg::op_ori, mips_pkg::op_xori,
					mips_pkg::op_lui: next_state = mips_pkg::st_exec_i;
					default: instr_done = 1'b1;  // unknown opcode, back to fetch
				endcase
			end
			mips_pkg::st_mem_addr: begin
				ctrl.alu_src_a = mips_pkg::src_a_reg;  // base + offset
				ctrl.alu_src_b = mips_pkg::src_b_ext;
				ctrl.alu_op    = mips_pkg::alu_add;
				next_state     = (opcode == mips_pkg::op_lw) ? mips_pkg::st_mem_read
				                                            : mips_pkg::st_mem_write;
			end
			mips_pkg::st_mem_read: begin
				ctrl.iord  = 1'b1;  // mdr picks up the word
				next_state = mips_pkg::st_mem_wb;
			end
			mips_pkg::st_mem_wb: begin
				ctrl.reg_write  = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.reg_dst    = mips_pkg::dst_rt;
				instr_done      = 1'b1;
			end
			mips_pkg::st_mem_write: begin
				ctrl.iord      = 1'b1;
				ctrl.mem_write = 1'b1;  // single cycle store strobe
				instr_done     = 1'b1;
			end
			mips_pkg::st_exec_r: begin
				ctrl.alu_src_a = is_shift ? mips_pkg::src_a_shamt : mips_pkg::src_a_reg;
				ctrl.alu_src_b = mips_pkg::src_b_reg;
				case (funct)
					mips_pkg::fn_subu: ctrl.alu_op = mips_pkg::alu_sub;
					mips_pkg::fn_and:  ctrl.alu_op = mips_pkg::alu_and;
					mips_pkg::fn_or:   ctrl.alu_op = mips_pkg::alu_or;
					mips_pkg::fn_xor:  ctrl.alu_op = mips_pkg::alu_xor;
					mips_pkg::fn_nor:  ctrl.alu_op = mips_pkg::alu_nor;
					mips_pkg::fn_slt:  ctrl.alu_op = mips_pkg::alu_slt;
					mips_pkg::fn_sltu: ctrl.alu_op = mips_pkg::alu_sltu;
					mips_pkg::fn_sll:  ctrl.alu_op = mips_pkg::alu_sll;
					mips_pkg::fn_srl:  ctrl.alu_op = mips_pkg::alu_srl;
					default:           ctrl.alu_op = mips_pkg::alu_add;  // addu
				endcase
				next_state = mips_pkg::st_alu_wb;
			end
			mips_pkg::st_exec_i: begin
				ctrl.alu_src_a = mips_pkg::src_a_reg;
				ctrl.alu_src_b = mips_pkg::src_b_ext;
				case (opcode)
					mips_pkg::op_slti:  ctrl.alu_op = mips_pkg::alu_slt;
					mips_pkg::op_sltiu: ctrl.alu_op = mips_pkg::alu_sltu;
					mips_pkg::op_andi:  ctrl.alu_op = mips_pkg::alu_and;
					mips_pkg::op_ori:   ctrl.alu_op = mips_pkg::alu_or;
					mips_pkg::op_xori:  ctrl.alu_op = mips_pkg::alu_xor;
					mips_pkg::op_lui:   ctrl.alu_op = mips_pkg::alu_lui;
					default:            ctrl.alu_op = mips_pkg::alu_add;  // addiu
				endcase
				// logical immediates are zero extended
				ctrl.ext_zero = (opcode == mips_pkg::op_andi) || (opcode == mips_pkg::op_ori)
				             || (opcode == mips_pkg::op_xori);
				next_state = mips_pkg::st_alu_wb;
			end
			mips_pkg::st_alu_wb: begin
				ctrl.reg_write = 1'b1;  // from alu_out
				ctrl.reg_dst   = (opcode == mips_pkg::op_rtype) ? mips_pkg::dst_rd
				                                               : mips_pkg::dst_rt;
				instr_done     = 1'b1;
			end
			mips_pkg::st_branch: begin
				ctrl.alu_src_a = mips_pkg::src_a_reg;  // rs - rt for zero flag
				ctrl.alu_src_b = mips_pkg::src_b_reg;
				ctrl.alu_op    = mips_pkg::alu_sub;
				ctrl.branch_eq = (opcode == mips_pkg::op_beq);
				ctrl.branch_ne = (opcode == mips_pkg::op_bne);
				ctrl.pc_src    = mips_pkg::pc_alu_out;
				instr_done     = 1'b1;
			end
			mips_pkg::st_jump: begin
				ctrl.pc_write = 1'b1;
				ctrl.pc_src   = (opcode == mips_pkg::op_rtype) ? mips_pkg::pc_reg_a  // jr
				                                              : mips_pkg::pc_jump;
				if (opcode == mips_pkg::op_jal) begin
					ctrl.reg_write = 1'b1;  // r31 <= pc + 4
					ctrl.reg_dst   = mips_pkg::dst_link;
				end
				instr_done = 1'b1;
			end
			default: next_state = mips_pkg::st_fetch;
		endcase
	end

endmodule

// File: src/mips.sv
`timescale 1ns/1ps

module mips (
	input  logic            clk,
	input  logic            rstb,
	input  mips_pkg::ctrl_t ctrl,
	input  logic [31:0]     mem_rd_data,
	output logic [31:0]     instr,
	output logic [31:0]     mem_addr,
	output logic [31:0]     mem_wr_data,
	output logic            mem_wr_ena,
	output logic [31:0]     pc
);

	logic [31:0] mdr, reg_a, reg_b, alu_out;  // inter-cycle holding regs
	logic [31:0] src_a, src_b, alu_result, ext_imm;
	logic [31:0] rd_data1, rd_data2, wr_data, pc_next;
	logic [mips_pkg::reg_aw-1:0] wr_addr;
	logic        alu_zero, pc_en;

	// imm extend, sign unless logical op
	assign ext_imm = ctrl.ext_zero ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

	always_comb begin
		case (ctrl.alu_src_a)
			mips_pkg::src_a_reg:   src_a = reg_a;
			mips_pkg::src_a_shamt: src_a = {27'b0, instr[10:6]};
			default:               src_a = pc;
		endcase
		case (ctrl.alu_src_b)
			mips_pkg::src_b_reg:  src_b = reg_b;
			mips_pkg::src_b_four: src_b = 32'd4;
			mips_pkg::src_b_ext:  src_b = ext_imm;
			default:              src_b = {ext_imm[29:0], 2'b00};  // word offset
		endcase
	end

	alu u_alu (
		.a      (src_a),
		.b      (src_b),
		.op     (ctrl.alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// writeback target and value
	always_comb begin
		case (ctrl.reg_dst)
			mips_pkg::dst_rt: wr_addr = instr[20:16];
			mips_pkg::dst_rd: wr_addr = instr[15:11];
			default:          wr_addr = mips_pkg::link_reg;
		endcase
		if (ctrl.reg_dst == mips_pkg::dst_link)
			wr_data = pc;  // already pc + 4 after fetch
		else if (ctrl.mem_to_reg)
			wr_data = mdr;
		else
			wr_data = alu_out;
	end

	register_file u_regs (
		.clk      (clk),
		.rstb     (rstb),
		.rd_addr1 (instr[25:21]),  // rs
		.rd_addr2 (instr[20:16]),  // rt
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.wr_ena   (ctrl.reg_write),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2)
	);

	// memory side
	assign mem_addr    = ctrl.iord ? alu_out : pc;
	assign mem_wr_data = reg_b;
	assign mem_wr_ena  = ctrl.mem_write;

	// pc update, branch resolved here from the zero flag
	assign pc_en = ctrl.pc_write
	            || (ctrl.branch_eq && alu_zero)
	            || (ctrl.branch_ne && !alu_zero);

	always_comb begin
		case (ctrl.pc_src)
			mips_pkg::pc_alu_result: pc_next = alu_result;
			mips_pkg::pc_alu_out:    pc_next = alu_out;  // branch target from decode
			mips_pkg::pc_jump:       pc_next = {pc[31:28], instr[25:0], 2'b00};
			default:                 pc_next = reg_a;    // jr
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstb) begin
			pc    <= '0;
			instr <= '0;
		end else begin
			if (pc_en)
				pc <= pc_next;
			if (ctrl.ir_write)
				instr <= mem_rd_data;
		end
	end

	// reloaded every cycle, consumed one state later
	always_ff @(posedge clk) begin
		mdr     <= mem_rd_data;
		reg_a   <= rd_data1;
		reg_b   <= rd_data2;
		alu_out <= alu_result;
	end

endmodule

// File: src/mips_pkg.sv
package mips_pkg;

	// sizes
	localparam int word_w    = 32;
	localparam int mem_words = 1024;               // 4 KiB unified memory
	localparam int mem_aw    = $clog2(mem_words);  // word index bits
	localparam int reg_count = 32;
	localparam int reg_aw    = 5;
	localparam logic [reg_aw-1:0] link_reg = 5'd31; // jal return address

	// primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addiu = 6'h09,
		op_slti  = 6'h0a,
		op_sltiu = 6'h0b,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_xori  = 6'h0e,
		op_lui   = 6'h0f,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_e;

	// function codes, instr[5:0] of r-type
	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_srl  = 6'h02,
		fn_jr   = 6'h08,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_lui
	} alu_op_e;

	typedef enum logic [3:0] {
		st_fetch, st_decode, st_mem_addr, st_mem_read, st_mem_wb, st_mem_write,
		st_exec_r, st_alu_wb, st_exec_i, st_branch, st_jump
	} ctrl_state_e;

	typedef enum logic [1:0] {src_a_pc, src_a_reg, src_a_shamt} alu_src_a_e;
	typedef enum logic [1:0] {src_b_reg, src_b_four, src_b_ext, src_b_ext_sl2} alu_src_b_e;
	typedef enum logic [1:0] {dst_rt, dst_rd, dst_link} reg_dst_e;
	typedef enum logic [1:0] {pc_alu_result, pc_alu_out, pc_jump, pc_reg_a} pc_src_e;

	// full datapath control word, 21 bits
	typedef struct packed {
		logic       pc_write;
		logic       iord;       // memory address from alu_out, else pc
		logic       mem_write;
		logic       ir_write;
		logic       reg_write;
		logic       mem_to_reg;
		logic       ext_zero;   // zero extend imm
		logic       branch_eq;
		logic       branch_ne;
		alu_src_a_e alu_src_a;
		alu_src_b_e alu_src_b;
		reg_dst_e   reg_dst;
		pc_src_e    pc_src;
		alu_op_e    alu_op;
	} ctrl_t;

endpackage

// File: src/mips_system.sv
`timescale 1ns/1ps

module mips_system (
	input  logic                        clk,
	input  logic                        rstb,
	input  logic                        load_ena,
	input  logic [mips_pkg::mem_aw-1:0] load_addr,
	input  logic [31:0]                 load_data,
	output logic [31:0]                 pc,
	output logic                        instr_done,
	output logic                        mem_wr_ena,
	output logic [31:0]                 mem_addr,
	output logic [31:0]                 mem_wr_data
);

	mips_pkg::ctrl_t ctrl;
	logic [31:0]     instr, mem_rd_data;

	control_unit u_ctrl (
		.clk        (clk),
		.rstb       (rstb),
		.instr      (instr),
		.ctrl       (ctrl),
		.instr_done (instr_done)
	);

	mips u_core (
		.clk         (clk),
		.rstb        (rstb),
		.ctrl        (ctrl),
		.mem_rd_data (mem_rd_data),
		.instr       (instr),
		.mem_addr    (mem_addr),
		.mem_wr_data (mem_wr_data),
		.mem_wr_ena  (mem_wr_ena),
		.pc          (pc)
	);

	unified_memory u_mem (
		.clk       (clk),
		.addr      (mem_addr),
		.wr_data   (mem_wr_data),
		.wr_ena    (mem_wr_ena),
		.load_ena  (load_ena),
		.load_addr (load_addr),
		.load_data (load_data),
		.rd_data   (mem_rd_data)
	);

endmodule

// File: src/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic                        clk,
	input  logic                        rstb,
	input  logic [mips_pkg::reg_aw-1:0] rd_addr1,
	input  logic [mips_pkg::reg_aw-1:0] rd_addr2,
	input  logic [mips_pkg::reg_aw-1:0] wr_addr,
	input  logic [mips_pkg::word_w-1:0] wr_data,
	input  logic                        wr_ena,
	output logic [mips_pkg::word_w-1:0] rd_data1,
	output logic [mips_pkg::word_w-1:0] rd_data2
);

	logic [mips_pkg::word_w-1:0] regs [mips_pkg::reg_count];

	always_ff @(posedge clk) begin
		if (!rstb) begin
			for (int i = 0; i < mips_pkg::reg_count; i++)
				regs[i] <= '0;
		end else if (wr_ena && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;  // r0 stays zero
		end
	end

	// async reads, old value on same cycle write
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

endmodule

// File: src/unified_memory.sv
`timescale 1ns/1ps

module unified_memory (
	input  logic                        clk,
	input  logic [31:0]                 addr,      // byte address
	input  logic [mips_pkg::word_w-1:0] wr_data,
	input  logic                        wr_ena,
	input  logic                        load_ena,  // boot load, held in reset
	input  logic [mips_pkg::mem_aw-1:0] load_addr, // word index
	input  logic [mips_pkg::word_w-1:0] load_data,
	output logic [mips_pkg::word_w-1:0] rd_data
);

	logic [mips_pkg::word_w-1:0] mem [mips_pkg::mem_words];
	logic [mips_pkg::mem_aw-1:0] word_idx;

	// word index, upper bits wrap
	assign word_idx = addr[mips_pkg::mem_aw+1:2];

	always_ff @(posedge clk) begin
		if (load_ena)
			mem[load_addr] <= load_data;  // boot port wins
		else if (wr_ena)
			mem[word_idx] <= wr_data;
	end

	assign rd_data = mem[word_idx];  // same cycle read

endmodule
